// ==== src/fe_isa_pkg.sv ====
`default_nettype none

package fe_isa_pkg;

    // instruction word and register index widths
    localparam int unsigned INST_W     = 32;
    localparam int unsigned INST_BYTES = 4;
    localparam int unsigned REG_IDX_W  = 5;

    // register class lives in the top three bits
    localparam int unsigned CLASS_LSB = 29;
    localparam int unsigned CLASS_W   = 3;

    // register field positions
    localparam int unsigned RD_LSB = 0;
    localparam int unsigned RJ_LSB = 5;
    localparam int unsigned RK_LSB = 10;

    typedef logic [INST_W-1:0]    inst_word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // r0 doubles as "no register"
    localparam reg_idx_t REG_ZERO = reg_idx_t'(0);
    // link register written by bl
    localparam reg_idx_t REG_RA   = reg_idx_t'(1);

    // class field value maps in order onto this list
    typedef enum logic [CLASS_W-1:0] {
        REG_I     = 3'd0,
        REG_RW    = 3'd1,
        REG_RRW   = 3'd2,
        REG_RR    = 3'd3,
        REG_BL    = 3'd4,
        REG_RDCNT = 3'd5,
        REG_XCHG  = 3'd6,
        REG_IDLE  = 3'd7
    } reg_type_e;

endpackage

`default_nettype wire

// ==== src/fe_pipe_pkg.sv ====
`default_nettype none

package fe_pipe_pkg;

    import fe_isa_pkg::*;

    localparam int unsigned PC_W        = 32;
    localparam int unsigned FETCH_BYTES = 8;
    // address bit that selects the upper word of a pair
    localparam int unsigned SLOT_BIT    = $clog2(FETCH_BYTES) - 1;

    localparam int unsigned QUEUE_DEPTH = 8;
    localparam int unsigned QUEUE_PTR_W = 3;

    typedef logic [PC_W-1:0]        pc_t;
    typedef logic [QUEUE_PTR_W-1:0] q_ptr_t;
    // one bit wider than the pointer, holds 0 to QUEUE_DEPTH
    typedef logic [QUEUE_PTR_W:0]   q_count_t;

    localparam pc_t RESET_PC = 32'h1C00_0000;

    typedef struct packed {
        reg_idx_t r0;
        reg_idx_t r1;
        reg_idx_t w;
    } reg_info_t;

    // slot 0 holds the word at the lower address
    typedef struct packed {
        logic             valid;
        inst_word_t [1:0] inst;
    } fetch_resp_t;

    typedef struct packed {
        logic flush;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        pc_t        pc;
        inst_word_t inst;
        reg_type_e  rtype;
        reg_info_t  regs;
    } fe_inst_t;

    typedef enum logic [1:0] {
        FE_RUN   = 2'd0,
        FE_SLEEP = 2'd1,
        FE_FLUSH = 2'd2
    } fe_state_e;

endpackage

`default_nettype wire

// ==== src/fe_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_ctrl_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   idle_req_i,
    input  logic                   irq_i,
    input  fe_pipe_pkg::redirect_t redirect_i,
    output fe_pipe_pkg::fe_state_e state_o,
    output logic                   fetch_en_o,
    output logic                   drop_resp_o,
    output logic                   flush_o
);

    import fe_pipe_pkg::*;

    fe_state_e state_q;
    fe_state_e state_d;
    logic      fetch_en_q;

    always_comb begin
        state_d = state_q;
        // redirect wins over everything, including sleep
        if (redirect_i.flush) begin
            state_d = FE_FLUSH;
        end else begin
            case (state_q)
                FE_RUN, FE_FLUSH: begin
                    if (idle_req_i && !irq_i) begin
                        state_d = FE_SLEEP;
                    end else begin
                        state_d = FE_RUN;
                    end
                end
                FE_SLEEP: begin
                    if (irq_i) begin
                        state_d = FE_RUN;
                    end
                end
                default: state_d = FE_RUN;
            endcase
        end
    end

    // fetch enable is held low through reset, so no request leaves before release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= FE_RUN;
            fetch_en_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            fetch_en_q <= (state_d != FE_SLEEP);
        end
    end

    assign state_o     = state_q;
    assign fetch_en_o  = fetch_en_q;
    // the pair requested in the redirect cycle comes back during flush
    assign drop_resp_o = (state_q == FE_FLUSH);
    assign flush_o     = redirect_i.flush;

endmodule

`default_nettype wire

// ==== src/fe_pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_en_i,
    input  fe_pipe_pkg::redirect_t redirect_i,
    input  fe_pipe_pkg::q_count_t  free_slots_i,
    output logic                   fetch_req_o,
    output fe_pipe_pkg::pc_t       fetch_addr_o,
    output logic [1:0]             slot_mask_o,
    output fe_pipe_pkg::pc_t       resp_pc_o
);

    import fe_pipe_pkg::*;

    pc_t        pc_q;
    logic       inflight_q;
    logic [1:0] mask_q;
    pc_t        resp_pc_q;
    logic [1:0] req_mask;
    q_count_t   reserved;
    q_count_t   needed;

    assign fetch_addr_o = pc_q & ~pc_t'(FETCH_BYTES - 1);
    // odd word target, lower slot is skipped
    assign req_mask     = pc_q[SLOT_BIT] ? 2'b10 : 2'b11;

    // space already promised to the pair still on its way back
    assign reserved    = inflight_q ? (q_count_t'(mask_q[0]) + q_count_t'(mask_q[1])) : '0;
    assign needed      = reserved + q_count_t'(2);
    assign fetch_req_o = fetch_en_i && (free_slots_i >= needed);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q       <= RESET_PC;
            inflight_q <= 1'b0;
        end else begin
            inflight_q <= fetch_req_o;
            if (redirect_i.flush) begin
                pc_q <= redirect_i.target;
            end else if (fetch_req_o) begin
                pc_q <= fetch_addr_o + pc_t'(FETCH_BYTES);
            end
        end
    end

    // lined up with the memory answer one cycle later
    always_ff @(posedge clk) begin
        mask_q    <= req_mask;
        resp_pc_q <= fetch_addr_o;
    end

    assign slot_mask_o = mask_q;
    assign resp_pc_o   = resp_pc_q;

endmodule

`default_nettype wire

// ==== src/fe_predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_predecode (
    input  fe_pipe_pkg::fetch_resp_t     fetch_resp_i,
    input  fe_pipe_pkg::pc_t             resp_pc_i,
    input  logic [1:0]                   slot_mask_i,
    input  logic                         drop_resp_i,
    output fe_pipe_pkg::fe_inst_t [1:0]  dec_o,
    output logic [1:0]                   dec_valid_o
);

    import fe_isa_pkg::*;
    import fe_pipe_pkg::*;

    fe_inst_t [1:0] slot;
    logic [1:0]     slot_ok;

    function automatic reg_info_t get_reg_info(input reg_type_e rtype, input inst_word_t word);
        reg_info_t info;
        reg_idx_t  rd;
        reg_idx_t  rj;
        reg_idx_t  rk;
        rd      = word[RD_LSB +: REG_IDX_W];
        rj      = word[RJ_LSB +: REG_IDX_W];
        rk      = word[RK_LSB +: REG_IDX_W];
        info.r0 = REG_ZERO;
        info.r1 = REG_ZERO;
        info.w  = REG_ZERO;
        case (rtype)
            REG_RW: begin
                info.r1 = rj;
                info.w  = rd;
            end
            REG_RRW: begin
                info.r0 = rk;
                info.r1 = rj;
                info.w  = rd;
            end
            REG_RR: begin
                info.r0 = rd;
                info.r1 = rj;
            end
            REG_BL: begin
                info.w = REG_RA;
            end
            REG_RDCNT: begin
                // only one of rd and rj is nonzero in the encoding
                info.w = rd | rj;
            end
            REG_XCHG: begin
                info.r0 = rd;
                info.r1 = rj;
                info.w  = rd;
            end
            // I and IDLE classes touch no registers
            default: begin
            end
        endcase
        return info;
    endfunction

    function automatic fe_inst_t decode_slot(input inst_word_t word, input pc_t pc);
        fe_inst_t res;
        res.pc    = pc;
        res.inst  = word;
        res.rtype = reg_type_e'(word[CLASS_LSB +: CLASS_W]);
        res.regs  = get_reg_info(res.rtype, word);
        return res;
    endfunction

    always_comb begin
        slot[0] = decode_slot(fetch_resp_i.inst[0], resp_pc_i);
        slot[1] = decode_slot(fetch_resp_i.inst[1], resp_pc_i + pc_t'(INST_BYTES));
        slot_ok = {2{fetch_resp_i.valid && !drop_resp_i}} & slot_mask_i;

        dec_o[1] = slot[1];
        // lone upper word moves down to slot 0
        if (slot_ok[0]) begin
            dec_o[0]    = slot[0];
            dec_valid_o = {slot_ok[1], 1'b1};
        end else begin
            dec_o[0]    = slot[1];
            dec_valid_o = {1'b0, slot_ok[1]};
        end
    end

endmodule

`default_nettype wire

// ==== src/fe_inst_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_inst_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush_i,
    input  fe_pipe_pkg::fe_inst_t [1:0] wr_i,
    input  logic [1:0]                  wr_valid_i,
    input  logic [1:0]                  issue_num_i,
    input  logic                        backend_stall_i,
    output fe_pipe_pkg::fe_inst_t [1:0] rd_o,
    output logic [1:0]                  rd_valid_o,
    output fe_pipe_pkg::q_count_t       free_slots_o
);

    import fe_pipe_pkg::*;

    fe_inst_t mem [QUEUE_DEPTH];

    q_ptr_t   wr_ptr_q;
    q_ptr_t   rd_ptr_q;
    q_count_t count_q;
    q_ptr_t   wr_ptr_nx;
    q_ptr_t   rd_ptr_nx;
    q_count_t push_num;
    q_count_t pop_num;
    q_count_t issue_cap;

    assign wr_ptr_nx = wr_ptr_q + q_ptr_t'(1);
    assign rd_ptr_nx = rd_ptr_q + q_ptr_t'(1);

    // head pair shown straight from storage
    assign rd_o[0]       = mem[rd_ptr_q];
    assign rd_o[1]       = mem[rd_ptr_nx];
    assign rd_valid_o[0] = (count_q != '0);
    assign rd_valid_o[1] = (count_q > q_count_t'(1));
    assign free_slots_o  = q_count_t'(QUEUE_DEPTH) - count_q;

    always_comb begin
        push_num  = q_count_t'(wr_valid_i[0]) + q_count_t'(wr_valid_i[1]);
        // at most two per cycle, never more than what is held
        issue_cap = (issue_num_i > 2'd2) ? q_count_t'(2) : q_count_t'(issue_num_i);
        if (backend_stall_i) begin
            pop_num = '0;
        end else if (issue_cap > count_q) begin
            pop_num = count_q;
        end else begin
            pop_num = issue_cap;
        end
    end

    // upper write follows the lower one when both are valid
    always_ff @(posedge clk) begin
        if (wr_valid_i[0]) begin
            mem[wr_ptr_q] <= wr_i[0];
        end
        if (wr_valid_i[1]) begin
            mem[wr_valid_i[0] ? wr_ptr_nx : wr_ptr_q] <= wr_i[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // same-cycle writes are thrown away too
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + q_ptr_t'(push_num);
            rd_ptr_q <= rd_ptr_q + q_ptr_t'(pop_num);
            count_q  <= count_q + push_num - pop_num;
        end
    end

endmodule

`default_nettype wire

// ==== src/fe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_top (
    input  logic                        clk,
    input  logic                        rst_n,

    // instruction memory port
    output logic                        fetch_req_o,
    output fe_pipe_pkg::pc_t            fetch_addr_o,
    input  fe_pipe_pkg::fetch_resp_t    fetch_resp_i,

    // backend side
    input  fe_pipe_pkg::redirect_t      redirect_i,
    input  logic [1:0]                  issue_num_i,
    input  logic                        backend_stall_i,
    output fe_pipe_pkg::fe_inst_t [1:0] inst_o,
    output logic [1:0]                  inst_valid_o,

    // privilege levels
    input  logic                        idle_req_i,
    input  logic                        irq_i
);

    import fe_pipe_pkg::*;

    fe_state_e      fe_state;
    logic           fetch_en;
    logic           drop_resp;
    logic           flush;
    q_count_t       free_slots;
    logic [1:0]     slot_mask;
    pc_t            resp_pc;
    fe_inst_t [1:0] dec;
    logic [1:0]     dec_valid;

    fe_ctrl_fsm u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .idle_req_i  (idle_req_i),
        .irq_i       (irq_i),
        .redirect_i  (redirect_i),
        .state_o     (fe_state),
        .fetch_en_o  (fetch_en),
        .drop_resp_o (drop_resp),
        .flush_o     (flush)
    );

    fe_pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_en_i   (fetch_en),
        .redirect_i   (redirect_i),
        .free_slots_i (free_slots),
        .fetch_req_o  (fetch_req_o),
        .fetch_addr_o (fetch_addr_o),
        .slot_mask_o  (slot_mask),
        .resp_pc_o    (resp_pc)
    );

    fe_predecode u_predecode (
        .fetch_resp_i (fetch_resp_i),
        .resp_pc_i    (resp_pc),
        .slot_mask_i  (slot_mask),
        .drop_resp_i  (drop_resp),
        .dec_o        (dec),
        .dec_valid_o  (dec_valid)
    );

    fe_inst_queue u_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush),
        .wr_i            (dec),
        .wr_valid_i      (dec_valid),
        .issue_num_i     (issue_num_i),
        .backend_stall_i (backend_stall_i),
        .rd_o            (inst_o),
        .rd_valid_o      (inst_valid_o),
        .free_slots_o    (free_slots)
    );

endmodule

`default_nettype wire

// ==== tb/fe_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   fetch_req_i,
    input fe_pipe_pkg::pc_t       fetch_addr_i,
    input logic [1:0]             inst_valid_i,
    input fe_pipe_pkg::fe_state_e state_i
);

    import fe_pipe_pkg::*;

    int unsigned assert_fails = 0;

    // upper output slot never valid on its own
    a_valid_order: assert property (@(posedge clk) disable iff (!rst_n)
        inst_valid_i[1] |-> inst_valid_i[0])
    else begin
        assert_fails++;
        $error("inst_valid_o bit 1 high while bit 0 is low");
    end

    a_no_fetch_in_sleep: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == FE_SLEEP) |-> !fetch_req_i)
    else begin
        assert_fails++;
        $error("fetch request issued while the frontend sleeps");
    end

    // pair addresses stay 8-byte aligned
    a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_addr_i[2:0] == 3'b000)
    else begin
        assert_fails++;
        $error("fetch address not aligned to a pair");
    end

endmodule

bind fe_top fe_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req_i  (fetch_req_o),
    .fetch_addr_i (fetch_addr_o),
    .inst_valid_i (inst_valid_o),
    .state_i      (fe_state)
);

`default_nettype wire

// ==== tb/fe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_tb;

    import fe_isa_pkg::*;
    import fe_pipe_pkg::*;

    localparam logic [31:0] FIRST_PC       = 32'h1C00_0000;
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam int          SLEEP_SETTLE   = 10;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           fetch_req;
    pc_t            fetch_addr;
    fetch_resp_t    fetch_resp;
    redirect_t      redirect;
    logic [1:0]     issue_num;
    logic           backend_stall;
    fe_inst_t [1:0] inst;
    logic [1:0]     inst_valid;
    logic           idle_req;
    logic           irq;

    // loaded program words, anything else comes from the fill pattern
    logic [31:0] mem_words [logic [31:0]];

    int          ev_cyc [$];
    logic        ev_flush [$];
    logic [31:0] ev_target [$];
    logic        ev_idle [$];
    logic        ev_irq [$];
    logic [1:0]  ev_issue [$];
    logic        ev_stall [$];

    logic [31:0] exp_pc [$];
    logic [31:0] exp_type [$];
    logic [31:0] exp_r0 [$];
    logic [31:0] exp_r1 [$];
    logic [31:0] exp_w [$];

    int errors = 0;
    int timeouts = 0;
    int cyc = 0;
    int ev_ptr = 0;
    int exp_idx = 0;
    int sleep_cycles = 0;
    int nvalid;
    int npop;
    int waited;
    bit first_req_seen = 1'b0;

    fe_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_req_o     (fetch_req),
        .fetch_addr_o    (fetch_addr),
        .fetch_resp_i    (fetch_resp),
        .redirect_i      (redirect),
        .issue_num_i     (issue_num),
        .backend_stall_i (backend_stall),
        .inst_o          (inst),
        .inst_valid_o    (inst_valid),
        .idle_req_i      (idle_req),
        .irq_i           (irq)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        // class field zero, rest mixes every address bit
        return {3'b000, addr[28:0] ^ {26'd0, addr[31:29]}};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_trace();
        int          fd;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        int          ec;
        int          f;
        int          g;
        int          h;
        int          k;
        int          m;
        fd = $fopen("tb/fe_trace.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "M %h %h", a, b) == 2) begin
                mem_words[a] = b;
            end else if ($sscanf(line, "E %d %d %h %d %d %d %d", ec, f, a, g, h, k, m) == 7) begin
                ev_cyc.push_back(ec);
                ev_flush.push_back(f[0]);
                ev_target.push_back(a);
                ev_idle.push_back(g[0]);
                ev_irq.push_back(h[0]);
                ev_issue.push_back(k[1:0]);
                ev_stall.push_back(m[0]);
            end else if ($sscanf(line, "X %h %h %h %h %h", a, b, c, d, e) == 5) begin
                exp_pc.push_back(a);
                exp_type.push_back(b);
                exp_r0.push_back(c);
                exp_r1.push_back(d);
                exp_w.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    task automatic compare_inst(input fe_inst_t got);
        check_value("pc", got.pc, exp_pc[exp_idx]);
        // word must be the one the memory model holds at that pc
        check_value("instruction word", got.inst, read_word(exp_pc[exp_idx]));
        check_value("register class", 32'(got.rtype), exp_type[exp_idx]);
        check_value("read register 0", 32'(got.regs.r0), exp_r0[exp_idx]);
        check_value("read register 1", 32'(got.regs.r1), exp_r1[exp_idx]);
        check_value("write register", 32'(got.regs.w), exp_w[exp_idx]);
        exp_idx++;
    endtask

    // memory answers every request exactly one cycle later
    always @(posedge clk) begin
        fetch_resp.valid   <= rst_n && fetch_req;
        fetch_resp.inst[0] <= read_word(fetch_addr);
        fetch_resp.inst[1] <= read_word(fetch_addr + 32'd4);
    end

    // backend and privilege events from the trace
    always @(posedge clk) begin
        redirect.flush <= 1'b0;
        if (rst_n) begin
            if (ev_ptr < ev_cyc.size() && ev_cyc[ev_ptr] == cyc) begin
                redirect.flush  <= ev_flush[ev_ptr];
                redirect.target <= ev_target[ev_ptr];
                idle_req        <= ev_idle[ev_ptr];
                irq             <= ev_irq[ev_ptr];
                issue_num       <= ev_issue[ev_ptr];
                backend_stall   <= ev_stall[ev_ptr];
                ev_ptr          <= ev_ptr + 1;
            end
            cyc <= cyc + 1;
        end
    end

    // outputs sampled mid-cycle, inputs are settled by then
    always @(negedge clk) begin
        if (rst_n) begin
            if (fetch_req && !first_req_seen) begin
                check_value("first fetch address", fetch_addr, FIRST_PC);
                first_req_seen = 1'b1;
            end
            nvalid = int'(inst_valid[0]) + int'(inst_valid[1]);
            npop   = backend_stall ? 0 : ((int'(issue_num) < nvalid) ? int'(issue_num) : nvalid);
            for (int k = 0; k < 2; k++) begin
                if (k < npop && exp_idx < exp_pc.size()) begin
                    compare_inst(inst[k]);
                end
            end
            if (idle_req && !irq) begin
                sleep_cycles++;
            end else begin
                sleep_cycles = 0;
            end
            // a sleeping frontend ends up with an empty queue and no fetches
            if (sleep_cycles > SLEEP_SETTLE) begin
                check_value("fetch request in sleep", 32'(fetch_req), 32'd0);
                check_value("valid outputs in sleep", 32'(inst_valid), 32'd0);
            end
        end
    end

    initial begin
        rst_n         = 1'b0;
        fetch_resp    = '0;
        redirect      = '0;
        issue_num     = 2'd0;
        backend_stall = 1'b0;
        idle_req      = 1'b0;
        irq           = 1'b0;
        read_trace();
        if (exp_pc.size() == 0) begin
            errors++;
            $display("trace file missing or without expected instructions");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("fetch request in reset", 32'(fetch_req), 32'd0);
        check_value("valid outputs in reset", 32'(inst_valid), 32'd0);
        @(posedge clk);
        rst_n <= 1'b1;
        waited = 0;
        while (exp_idx < exp_pc.size() && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (exp_idx < exp_pc.size()) begin
            timeouts++;
            $display("timeout waiting for issued instructions, %0d of %0d seen",
                     exp_idx, exp_pc.size());
        end
        $display("summary: %0d mismatches, %0d timeouts, %0d assertion failures, %0d checked",
                 errors, timeouts, dut.u_checker.assert_fails, exp_idx);
        if (errors == 0 && timeouts == 0 && dut.u_checker.assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== la_frontend.f ====
src/fe_isa_pkg.sv
src/fe_pipe_pkg.sv
src/fe_ctrl_fsm.sv
src/fe_pc_gen.sv
src/fe_predecode.sv
src/fe_inst_queue.sv
src/fe_top.sv
tb/fe_checker.sv
tb/fe_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the frontend testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fe_tb \
    -f la_frontend.f --Mdir obj_dir -o fe_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fe_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q '>>> FAIL' sim.log && exit 1
grep -q '>>> PASS' sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== tb/fe_trace.txt ====
# M addr word | E cycle flush target idle irq issue stall
# X pc class r0 r1 w (expected issue order, hex)
M 1C000000 00001483
M 1C000004 20001483
M 1C000008 40001483
M 1C00000C 60001483
M 1C000010 80001483
M 1C000014 A00000E0
M 1C000018 C0001483
M 1C00001C E0001483
M 1C000100 C0001483
M 1C000104 40002A1F
M 1C000108 60002A1F
M 1C00010C C0002A1F
E 0 0 0 0 0 0 0
E 20 0 0 0 0 2 0
E 24 0 0 0 0 0 1
E 40 0 0 0 0 1 0
E 48 1 1C000104 0 0 0 0
E 60 0 0 1 0 2 0
E 80 0 0 0 1 2 0
E 82 0 0 0 0 2 0
X 1C000000 0 0 0 0
X 1C000004 1 0 4 3
X 1C000008 2 5 4 3
X 1C00000C 3 3 4 0
X 1C000010 4 0 0 1
X 1C000014 5 0 0 7
X 1C000018 6 3 4 3
X 1C00001C 7 0 0 0
X 1C000020 0 0 0 0
X 1C000024 0 0 0 0
X 1C000028 0 0 0 0
X 1C00002C 0 0 0 0
X 1C000030 0 0 0 0
X 1C000034 0 0 0 0
X 1C000038 0 0 0 0
X 1C00003C 0 0 0 0
X 1C000104 2 0a 10 1f
X 1C000108 3 1f 10 0
X 1C00010C 6 1f 10 1f
X 1C000110 0 0 0 0
X 1C000114 0 0 0 0
X 1C000118 0 0 0 0
X 1C00011C 0 0 0 0
X 1C000120 0 0 0 0
X 1C000124 0 0 0 0
X 1C000128 0 0 0 0
X 1C00012C 0 0 0 0
X 1C000130 0 0 0 0
X 1C000134 0 0 0 0
X 1C000138 0 0 0 0
X 1C00013C 0 0 0 0
